//--- Makefile
# Verilator build and run of the peripheral block testbench

VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/periph_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral block widths
// Register word offsets
// Reset values and pad bit layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// Bus widths
`define PERIPH_ADR_W   4
`define PERIPH_DATA_W  32

// Peripheral widths
`define DSP_OPERAND_W  16
`define PAD_STATE_W    16
`define FLASH_PINS     4

// Word offsets on the slave port
`define REG_STATUS     4'd0
`define REG_DSP_A      4'd1
`define REG_DSP_B      4'd2
`define REG_DSP_RESULT 4'd3
`define REG_PAD_CTRL   4'd4
`define REG_PAD_DATA   4'd5
`define REG_FLASH_CTRL 4'd6

// LED status after reset, red on
`define STATUS_RESET   2'b01

// Gamepad latch layout
`define PAD_BIT_B      0
`define PAD_BIT_RIGHT  6
`define PAD_BIT_LEFT   7

`endif

//--- common/periph_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral types
// Flash control and DSP operand fields
// Bus write word union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "periph_macros.svh"

package periph_pkg;

    // Flash bit-bang control word
    typedef struct packed {
        logic [15:0]              reserved_hi;
        logic                     active;
        logic [4:0]               reserved_mid;
        logic                     csn;
        logic                     clk;
        logic [`FLASH_PINS-1:0]   in_en;
        logic [`FLASH_PINS-1:0]   din;
    } flash_ctrl_fields_t;

    // Multiplier operand word, low half only
    typedef struct packed {
        logic [`PERIPH_DATA_W-`DSP_OPERAND_W-1:0] reserved;
        logic [`DSP_OPERAND_W-1:0]                operand;
    } dsp_operand_fields_t;

    // Same write word as seen by each peripheral
    typedef union packed {
        logic [`PERIPH_DATA_W-1:0] raw;
        flash_ctrl_fields_t        flash;
        dsp_operand_fields_t       dsp;
    } wdata_u;

endpackage

//--- design/dsp_mult.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Signed 16x16 multiplier
// Operand registers and product register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_macros.svh"

module dsp_mult (
    input  logic                      vdp_clk,
    input  periph_pkg::wdata_u        wdata,
    input  logic                      dsp_a_we,
    input  logic                      dsp_b_we,
    output logic [`PERIPH_DATA_W-1:0] dsp_result
);
    logic signed [`DSP_OPERAND_W-1:0]   mult_a;
    logic signed [`DSP_OPERAND_W-1:0]   mult_b;
    logic signed [2*`DSP_OPERAND_W-1:0] product;

    // Both operands signed, full width product
    assign product = mult_a * mult_b;

    // Kept flat so operand and output FFs map into the MAC block
    always_ff @(posedge vdp_clk) begin
        if (dsp_a_we) begin
            mult_a <= wdata.dsp.operand;
        end

        if (dsp_b_we) begin
            mult_b <= wdata.dsp.operand;
        end

        dsp_result <= product;
    end

endmodule

//--- design/mmio_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave port
// Offset decode, read mux, LED status register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_macros.svh"

module mmio_decoder (
    input  logic                      vdp_clk,
    input  logic                      vdp_reset,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`PERIPH_ADR_W-1:0]  wb_adr,
    input  logic [`PERIPH_DATA_W-1:0] wb_dat_w,
    input  logic [`PERIPH_DATA_W-1:0] dsp_result,
    input  logic                      pad_bit,
    input  logic [`FLASH_PINS-1:0]    flash_pins,
    output logic [`PERIPH_DATA_W-1:0] wb_dat_r,
    output logic                      wb_ack,
    output periph_pkg::wdata_u        wdata,
    output logic                      dsp_a_we,
    output logic                      dsp_b_we,
    output logic                      pad_ctrl_we,
    output logic                      flash_ctrl_we,
    output logic                      led_r,
    output logic                      led_b
);
    logic                      req;
    logic                      wr_req;
    logic                      status_we;
    logic [1:0]                status;
    logic [`PERIPH_DATA_W-1:0] rd_sel;

    // New request only while no ack is pending
    assign req = wb_cyc && wb_stb && !wb_ack;
    assign wr_req = req && wb_we;

    // Master holds dat_w through the ack cycle
    assign wdata.raw = wb_dat_w;

    assign led_r = status[0];
    assign led_b = status[1];

    // Ack and write strobes share the same cycle
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            wb_ack <= 1'b0;
            status_we <= 1'b0;
            dsp_a_we <= 1'b0;
            dsp_b_we <= 1'b0;
            pad_ctrl_we <= 1'b0;
            flash_ctrl_we <= 1'b0;
        end else begin
            wb_ack <= req;
            status_we <= wr_req && (wb_adr == `REG_STATUS);
            dsp_a_we <= wr_req && (wb_adr == `REG_DSP_A);
            dsp_b_we <= wr_req && (wb_adr == `REG_DSP_B);
            pad_ctrl_we <= wr_req && (wb_adr == `REG_PAD_CTRL);
            flash_ctrl_we <= wr_req && (wb_adr == `REG_FLASH_CTRL);
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= `STATUS_RESET;
        end else if (status_we) begin
            status <= wb_dat_w[1:0];
        end
    end

    // Write-only and unmapped offsets read zero
    always_comb begin
        rd_sel = '0;
        case (wb_adr)
            `REG_STATUS:     rd_sel[1:0] = status;
            `REG_DSP_RESULT: rd_sel = dsp_result;
            `REG_PAD_DATA:   rd_sel[0] = pad_bit;
            `REG_FLASH_CTRL: rd_sel[`FLASH_PINS-1:0] = flash_pins;
            default:         rd_sel = '0;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (req) begin
            wb_dat_r <= rd_sel;
        end
    end

    a_ack_needs_req: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

    a_one_strobe: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        (dsp_a_we || dsp_b_we || pad_ctrl_we || flash_ctrl_we) |->
            (wb_ack && $onehot0({dsp_a_we, dsp_b_we, pad_ctrl_we, flash_ctrl_we})));

endmodule

//--- design/periph_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral block top level
// Decoder, multiplier, gamepad and flash control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_macros.svh"

module periph_top (
    input  logic                      vdp_clk,
    input  logic                      vdp_reset,

    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`PERIPH_ADR_W-1:0]  wb_adr,
    input  logic [`PERIPH_DATA_W-1:0] wb_dat_w,
    output logic [`PERIPH_DATA_W-1:0] wb_dat_r,
    output logic                      wb_ack,

    input  logic                      btn_1,
    input  logic                      btn_2,
    input  logic                      btn_3,
    output logic                      led_r,
    output logic                      led_b,

    output logic                      flash_clk,
    output logic                      flash_csn,
    output logic [`FLASH_PINS-1:0]    flash_din,
    output logic [`FLASH_PINS-1:0]    flash_in_en,
    input  logic [`FLASH_PINS-1:0]    flash_dout
);
    import periph_pkg::*;

    wdata_u                    wdata;
    logic                      dsp_a_we;
    logic                      dsp_b_we;
    logic                      pad_ctrl_we;
    logic                      flash_ctrl_we;
    logic [`PERIPH_DATA_W-1:0] dsp_result;
    logic                      pad_bit;
    logic [`FLASH_PINS-1:0]    flash_pins;

    mmio_decoder decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .dsp_result(dsp_result),
        .pad_bit(pad_bit),
        .flash_pins(flash_pins),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .wdata(wdata),
        .dsp_a_we(dsp_a_we),
        .dsp_b_we(dsp_b_we),
        .pad_ctrl_we(pad_ctrl_we),
        .flash_ctrl_we(flash_ctrl_we),
        .led_r(led_r),
        .led_b(led_b)
    );

    dsp_mult mult (
        .vdp_clk(vdp_clk),
        .wdata(wdata),
        .dsp_a_we(dsp_a_we),
        .dsp_b_we(dsp_b_we),
        .dsp_result(dsp_result)
    );

    pad_shifter pad (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .wdata(wdata),
        .pad_ctrl_we(pad_ctrl_we),
        .btn_1(btn_1),
        .btn_2(btn_2),
        .btn_3(btn_3),
        .pad_bit(pad_bit)
    );

    flash_ctrl flash (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .wdata(wdata),
        .flash_ctrl_we(flash_ctrl_we),
        .flash_dout(flash_dout),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_din(flash_din),
        .flash_in_en(flash_in_en),
        .flash_pins(flash_pins)
    );

endmodule

//--- flash/flash_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit-bang quad flash control
// Pin gating and data pin sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_macros.svh"

module flash_ctrl (
    input  logic                   vdp_clk,
    input  logic                   vdp_reset,
    input  periph_pkg::wdata_u     wdata,
    input  logic                   flash_ctrl_we,
    input  logic [`FLASH_PINS-1:0] flash_dout,
    output logic                   flash_clk,
    output logic                   flash_csn,
    output logic [`FLASH_PINS-1:0] flash_din,
    output logic [`FLASH_PINS-1:0] flash_in_en,
    output logic [`FLASH_PINS-1:0] flash_pins
);
    logic                   active_r;
    logic                   csn_r;
    logic                   clk_r;
    logic [`FLASH_PINS-1:0] in_en_r;
    logic [`FLASH_PINS-1:0] din_r;

    always_ff @(posedge vdp_clk) begin
        if (flash_ctrl_we) begin
            csn_r <= wdata.flash.csn;
            clk_r <= wdata.flash.clk;
            in_en_r <= wdata.flash.in_en;
            din_r <= wdata.flash.din;
        end
    end

    // Pin enable, cleared on reset
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            active_r <= 1'b0;
        end else if (flash_ctrl_we) begin
            active_r <= wdata.flash.active;
        end
    end

    // Idle pins while software has not taken the bus
    assign flash_csn = active_r ? csn_r : 1'b1;
    assign flash_clk = active_r ? clk_r : 1'b0;
    assign flash_in_en = active_r ? in_en_r : '0;
    assign flash_din = active_r ? din_r : '0;

    // Sampled every cycle for read-back
    always_ff @(posedge vdp_clk) begin
        flash_pins <= flash_dout;
    end

    // Releasing the bus drops all drivers by the next cycle
    a_idle_after_release: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        (flash_ctrl_we && !wdata.flash.active) |=>
            ((flash_in_en == '0) && flash_csn && !flash_clk));

endmodule

//--- pad/pad_shifter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gamepad control register
// Button latch and serial shift out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_macros.svh"

module pad_shifter (
    input  logic               vdp_clk,
    input  logic               vdp_reset,
    input  periph_pkg::wdata_u wdata,
    input  logic               pad_ctrl_we,
    input  logic               btn_1,
    input  logic               btn_2,
    input  logic               btn_3,
    output logic               pad_bit
);
    logic                    pad_latch;
    logic                    pad_clk;
    logic                    pad_clk_r;
    logic                    clk_rise;
    logic [`PAD_STATE_W-1:0] latch_value;
    logic [`PAD_STATE_W-1:0] pad_state;

    // Bit 0 latch, bit 1 clock
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch <= 1'b0;
            pad_clk <= 1'b0;
            pad_clk_r <= 1'b0;
        end else begin
            if (pad_ctrl_we) begin
                pad_latch <= wdata.raw[0];
                pad_clk <= wdata.raw[1];
            end
            pad_clk_r <= pad_clk;
        end
    end

    assign clk_rise = pad_clk && !pad_clk_r;

    // Three board buttons stand in for a real pad
    always_comb begin
        latch_value = '0;
        latch_value[`PAD_BIT_B] = btn_2;
        latch_value[`PAD_BIT_RIGHT] = btn_3;
        latch_value[`PAD_BIT_LEFT] = btn_1;
    end

    // Shift wins over a held latch
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_state <= '0;
        end else if (clk_rise) begin
            pad_state <= {1'b0, pad_state[`PAD_STATE_W-1:1]};
        end else if (pad_latch) begin
            pad_state <= latch_value;
        end
    end

    assign pad_bit = pad_state[0];

endmodule

//--- testbench/tb_periph.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the peripheral block
// Wishbone tasks, register model, compare process
// Ack counter and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "periph_macros.svh"

module tb_periph;
    localparam int N_STATUS     = 16;
    localparam int N_MULT       = 40;
    localparam int N_PAD_ROUNDS = 3;
    localparam int N_SHIFTS     = 18;
    localparam int N_FLASH      = 12;
    localparam int N_UNMAPPED   = 12;
    localparam int N_ACCESSES   = 1 + 2 * N_STATUS + 3 * N_MULT
                                + N_PAD_ROUNDS * (3 + 4 * N_SHIFTS) + 4 * N_FLASH + N_UNMAPPED;
    localparam int WATCHDOG_CYCLES = N_ACCESSES * 4 + 200;

    logic                      vdp_clk;
    logic                      vdp_reset;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`PERIPH_ADR_W-1:0]  wb_adr;
    logic [`PERIPH_DATA_W-1:0] wb_dat_w;
    logic [`PERIPH_DATA_W-1:0] wb_dat_r;
    logic                      wb_ack;
    logic                      btn_1;
    logic                      btn_2;
    logic                      btn_3;
    logic                      led_r;
    logic                      led_b;
    logic                      flash_clk;
    logic                      flash_csn;
    logic [`FLASH_PINS-1:0]    flash_din;
    logic [`FLASH_PINS-1:0]    flash_in_en;
    logic [`FLASH_PINS-1:0]    flash_dout;

    integer seed = 32'hadc0;
    int     errors = 0;
    int     checks = 0;
    int     ack_count = 0;
    int     access_count = 0;

    // Register model
    logic [1:0]                       model_status;
    logic signed [`DSP_OPERAND_W-1:0] model_a;
    logic signed [`DSP_OPERAND_W-1:0] model_b;
    logic [`PAD_STATE_W-1:0]          model_pad;
    logic [`FLASH_PINS-1:0]           model_dout;

    // Reads waiting for the compare process
    logic [31:0] act_q[$];
    logic [31:0] exp_q[$];
    logic [3:0]  adr_q[$];
    event        read_event;

    periph_top dut (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .btn_1(btn_1),
        .btn_2(btn_2),
        .btn_3(btn_3),
        .led_r(led_r),
        .led_b(led_b),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_din(flash_din),
        .flash_in_en(flash_in_en),
        .flash_dout(flash_dout)
    );

    always #50 vdp_clk = ~vdp_clk;

    // Buttons placed into the pad shift word
    function automatic logic [15:0] pad_layout(input logic b1, input logic b2, input logic b3);
        logic [15:0] v;
        v = '0;
        v[`PAD_BIT_B] = b2;
        v[`PAD_BIT_RIGHT] = b3;
        v[`PAD_BIT_LEFT] = b1;
        return v;
    endfunction

    // Expected read value for an offset, from the model
    function automatic logic [31:0] expected_read(input logic [3:0] adr);
        logic signed [31:0] product;
        logic [31:0]        value;
        product = model_a * model_b;
        value = '0;
        case (adr)
            4'd0:    value[1:0] = model_status;
            4'd3:    value = product;
            4'd5:    value[0] = model_pad[0];
            4'd6:    value[3:0] = model_dout;
            default: value = '0;
        endcase
        return value;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // One classic cycle, returns at the edge that ends ack
    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] data,
                             output logic [31:0] rdata);
        @(posedge vdp_clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= data;
        access_count++;
        do begin
            @(posedge vdp_clk);
        end while (!wb_ack);
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic bus_write(input logic [3:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    // Expected value taken now, compared later
    task automatic bus_read(input logic [3:0] adr);
        logic [31:0] rdata;
        bus_cycle(1'b0, adr, 32'h0, rdata);
        adr_q.push_back(adr);
        act_q.push_back(rdata);
        exp_q.push_back(expected_read(adr));
        -> read_event;
    endtask

    initial begin
        logic [31:0] act;
        logic [31:0] exp;
        logic [3:0]  adr;
        forever begin
            @(read_event);
            while (act_q.size() > 0) begin
                act = act_q.pop_front();
                exp = exp_q.pop_front();
                adr = adr_q.pop_front();
                check(act, exp, $sformatf("read of offset %0d", adr));
            end
        end
    end

    // Counts every cycle with ack high
    always @(posedge vdp_clk) begin
        if (wb_ack) begin
            ack_count <= ack_count + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge vdp_clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] word;
        logic [2:0]  btns;
        logic [3:0]  dout;
        vdp_clk = 1'b0;
        vdp_reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        btn_1 = 1'b0;
        btn_2 = 1'b0;
        btn_3 = 1'b0;
        flash_dout = '0;
        model_status = `STATUS_RESET;
        model_a = '0;
        model_b = '0;
        model_pad = '0;
        model_dout = '0;
        repeat (3) @(posedge vdp_clk);
        vdp_reset <= 1'b0;

        // Reset state
        @(negedge vdp_clk);
        check(32'(led_r), 32'd1, "led_r after reset");
        check(32'(led_b), 32'd0, "led_b after reset");
        check(32'(wb_ack), 32'd0, "wb_ack after reset");
        check(32'(flash_csn), 32'd1, "flash_csn after reset");
        check(32'(flash_clk), 32'd0, "flash_clk after reset");
        check(32'(flash_in_en), 32'd0, "flash_in_en after reset");
        bus_read(`REG_STATUS);

        for (int i = 0; i < N_STATUS; i++) begin
            rnd = $random(seed);
            bus_write(`REG_STATUS, rnd);
            model_status = rnd[1:0];
            @(negedge vdp_clk);
            check(32'(led_r), 32'(model_status[0]), "led_r follows status");
            check(32'(led_b), 32'(model_status[1]), "led_b follows status");
            bus_read(`REG_STATUS);
        end

        // Upper operand bits are random and must be ignored
        for (int i = 0; i < N_MULT; i++) begin
            rnd = $random(seed);
            bus_write(`REG_DSP_A, rnd);
            model_a = rnd[15:0];
            rnd = $random(seed);
            bus_write(`REG_DSP_B, rnd);
            model_b = rnd[15:0];
            bus_read(`REG_DSP_RESULT);
        end

        for (int r = 0; r < N_PAD_ROUNDS; r++) begin
            rnd = $random(seed);
            btns = (r == 0) ? 3'b111 : rnd[2:0];
            btn_1 <= btns[0];
            btn_2 <= btns[1];
            btn_3 <= btns[2];
            bus_write(`REG_PAD_CTRL, 32'h1);
            bus_write(`REG_PAD_CTRL, 32'h0);
            model_pad = pad_layout(btns[0], btns[1], btns[2]);
            bus_read(`REG_PAD_DATA);
            // Runs past 16 shifts to see zero fill
            for (int s = 0; s < N_SHIFTS; s++) begin
                bus_write(`REG_PAD_CTRL, 32'h0);
                bus_read(`REG_PAD_DATA);
                bus_write(`REG_PAD_CTRL, 32'h2);
                model_pad = model_pad >> 1;
                bus_read(`REG_PAD_DATA);
            end
        end

        for (int i = 0; i < N_FLASH; i++) begin
            rnd = $random(seed);
            dout = rnd[19:16];
            flash_dout <= dout;
            model_dout = dout;
            word = $random(seed);
            word[15] = 1'b1;
            bus_write(`REG_FLASH_CTRL, word);
            @(negedge vdp_clk);
            check(32'(flash_csn), 32'(word[9]), "flash_csn while active");
            check(32'(flash_clk), 32'(word[8]), "flash_clk while active");
            check(32'(flash_in_en), 32'(word[7:4]), "flash_in_en while active");
            check(32'(flash_din), 32'(word[3:0]), "flash_din while active");
            bus_read(`REG_FLASH_CTRL);
            rnd = $random(seed);
            dout = rnd[3:0];
            flash_dout <= dout;
            model_dout = dout;
            word = $random(seed);
            word[15] = 1'b0;
            bus_write(`REG_FLASH_CTRL, word);
            @(negedge vdp_clk);
            check(32'(flash_csn), 32'd1, "flash_csn idle");
            check(32'(flash_clk), 32'd0, "flash_clk idle");
            check(32'(flash_in_en), 32'd0, "flash_in_en idle");
            check(32'(flash_din), 32'd0, "flash_din idle");
            bus_read(`REG_FLASH_CTRL);
        end

        // Write-only and unmapped offsets
        bus_read(`REG_DSP_A);
        bus_read(`REG_DSP_B);
        bus_read(`REG_PAD_CTRL);
        for (int i = 7; i < 16; i++) begin
            bus_read(4'(i));
        end

        repeat (2) @(posedge vdp_clk);
        check(32'(ack_count), 32'(access_count), "ack cycles per access");
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+common
common/periph_pkg.sv
design/mmio_decoder.sv
design/dsp_mult.sv
pad/pad_shifter.sv
flash/flash_ctrl.sv
design/periph_top.sv
testbench/tb_periph.sv
